/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ni_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
logic/ni_pkg.sv
logic/ni_regs.sv
logic/ni_packetizer.sv
logic/ni_flit_fifo.sv
logic/ni_depacketizer.sv
logic/ni_top.sv
bench/ni_tb.sv

/* bench/golden_packets.txt */
# dest send_ptr recv_ptr size expected_header_flit, then size data words (may wrap lines)
# all hex, header flit is flags 10 over {size, source 5a, dest}
11 00000100 00000800 3 200035a11 a0000001 b1c2d3e4 0badf00d
22 00000200 00000900 1 200015a22 12345678
33 00000300 00000a00 5 200055a33 00000000 ffffffff 55aa55aa
    aa55aa55 80000001
44 00000400 00000b00 c 2000c5a44 10000001 20000002 30000003 40000004 50000005 60000006
    70000007 80000008 90000009 a000000a b000000b c000000c

/* bench/ni_tb.sv */
`timescale 1ns/100ps
// testbench for the DMA network interface in loopback with a memory model
// packets, headers and words come from the golden file
module ni_tb;
    localparam int BUF_DEPTH = 8;
    localparam logic [7:0] EP_ADDR = 8'h5a;

    logic        clk;
    logic        reset;
    logic [7:0]  ep_addr_i;
    logic        s_stb_i;
    logic        s_we_i;
    logic [3:0]  s_addr_i;
    logic [31:0] s_dat_i;
    logic [31:0] s_dat_o;
    logic        s_ack_o;
    logic        m_rd_stb_o;
    logic [31:0] m_rd_addr_o;
    logic [31:0] m_rd_dat_i = 32'h0;
    logic        m_rd_ack_i = 1'b0;
    logic        m_wr_stb_o;
    logic [31:0] m_wr_addr_o;
    logic [31:0] m_wr_dat_o;
    logic        m_wr_ack_i = 1'b0;
    logic [33:0] flit_o;
    logic        flit_wr_o;
    logic        credit_i;
    logic [33:0] flit_i;
    logic        flit_wr_i;
    logic        credit_o;
    logic        irq_o;

    logic [31:0] src_mem [logic [31:0]];   // preloaded words behind the read port
    logic [31:0] dst_mem [logic [31:0]];   // filled by the write port
    int          rd_wait = 0;
    int          wr_wait = 0;
    logic [33:0] exp_flits [$];
    int          flit_cnt = 0;

    // current golden packet
    logic [31:0] dest;
    logic [31:0] sptr;
    logic [31:0] rptr;
    logic [31:0] size;
    logic [33:0] hdr;
    logic [31:0] pkt_words [$];

    ni_top #(.BUF_DEPTH(BUF_DEPTH), .ADDR_W(32)) ni_top_i (.*);

    // endpoint talks to itself
    assign flit_i    = flit_o;
    assign flit_wr_i = flit_wr_o;
    assign credit_i  = credit_o;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // unwritten addresses read back a pattern of the full address
    function automatic logic [31:0] src_word(input logic [31:0] addr);
        if (src_mem.exists(addr))
            return src_mem[addr];
        return addr ^ 32'hc3a5_5a3c;
    endfunction

    // memory model for both masters with a random ack delay
    always @(negedge clk) begin
        m_rd_ack_i = 1'b0;
        m_wr_ack_i = 1'b0;
        if (!reset && m_rd_stb_o) begin
            if (rd_wait == 0) begin
                m_rd_dat_i = src_word(m_rd_addr_o);
                m_rd_ack_i = 1'b1;
                rd_wait    = $urandom_range(3, 0);
            end else begin
                rd_wait--;
            end
        end
        if (!reset && m_wr_stb_o) begin
            if (wr_wait == 0) begin
                dst_mem[m_wr_addr_o] = m_wr_dat_o;
                m_wr_ack_i           = 1'b1;
                wr_wait              = $urandom_range(3, 0);
            end else begin
                wr_wait--;
            end
        end
    end

    // every flit on the wire against the expected stream
    always @(negedge clk) begin
        if (!reset && flit_wr_o) begin
            if (flit_cnt >= exp_flits.size()) begin
                $display("unexpected flit %0h on flit_o at %0t", flit_o, $time);
                stop_with_failure();
            end else begin
                check_equal("flit_o", 64'(flit_o), 64'(exp_flits[flit_cnt]));
            end
            flit_cnt++;
        end
    end

    task automatic bus_access(input logic we, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int n;
        @(negedge clk);
        s_stb_i  = 1'b1;
        s_we_i   = we;
        s_addr_i = addr;
        s_dat_i  = wdata;
        n = 0;
        @(negedge clk);
        while (!s_ack_o) begin
            if (n == 20) begin
                $display("slave never acknowledged address %0d", addr);
                stop_with_failure();
            end
            n++;
            @(negedge clk);
        end
        rdata   = s_dat_o;
        s_stb_i = 1'b0;
        s_we_i  = 1'b0;
        @(negedge clk);
        check_equal("s_ack_o", 64'(s_ack_o), 64'(0));   // one ack cycle only
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(1'b1, addr, data, ignored);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic setup_reg(input logic [3:0] addr, input logic [31:0] data, input string name);
        logic [31:0] rd;
        write_reg(addr, data);
        read_reg(addr, rd);
        check_equal(name, 64'(rd), 64'(data));
    endtask

    task automatic run_packet();
        logic [31:0] rd;
        logic [1:0]  flags;
        logic        stall;
        int          base;
        int          i;
        int          n;
        stall = size > BUF_DEPTH;
        setup_reg(ni_pkg::SEND_DEST, dest, "SEND_DEST");
        setup_reg(ni_pkg::SEND_PTR, sptr, "SEND_PTR");
        setup_reg(ni_pkg::SEND_SIZE, size, "SEND_SIZE");
        setup_reg(ni_pkg::RECV_PTR, rptr, "RECV_PTR");
        setup_reg(ni_pkg::IRQ_EN, 32'h3, "IRQ_EN");
        exp_flits.push_back(hdr);
        for (i = 0; i < size; i++) begin
            src_mem[sptr + i] = pkt_words[i];
            flags = (i == size - 1) ? 2'b01 : 2'b00;   // tail on the last word
            exp_flits.push_back({flags, pkt_words[i]});
        end
        if (!stall)
            write_reg(ni_pkg::RECV_START, 32'h0);
        base = flit_cnt;
        write_reg(ni_pkg::SEND_START, 32'h0);
        write_reg(ni_pkg::SEND_START, 32'h0);   // lands while busy
        if (stall) begin
            n = 0;
            while (flit_cnt - base < BUF_DEPTH) begin
                if (n == 200) begin
                    $display("flit buffer never filled while the receiver was unarmed");
                    stop_with_failure();
                end
                n++;
                @(negedge clk);
            end
            repeat (40) @(negedge clk);
            check_equal("flit count", 64'(flit_cnt - base), 64'(BUF_DEPTH));
            read_reg(ni_pkg::STATUS, rd);
            check_equal("STATUS", 64'(rd & 32'h1f), 64'(32'h11));
            write_reg(ni_pkg::RECV_START, 32'h0);
        end
        n = 0;
        read_reg(ni_pkg::STATUS, rd);
        while (rd[3:2] != 2'b11) begin
            if (n == 300) begin
                $display("send and receive done flags never both set");
                stop_with_failure();
            end
            n++;
            read_reg(ni_pkg::STATUS, rd);
        end
        check_equal("irq_o", 64'(irq_o), 64'(1));
        check_equal("flit count", 64'(flit_cnt - base), 64'(size + 1));
        read_reg(ni_pkg::RECV_SRC, rd);
        check_equal("RECV_SRC", 64'(rd), 64'(EP_ADDR));
        read_reg(ni_pkg::RECV_SIZE, rd);
        check_equal("RECV_SIZE", 64'(rd), 64'(size));
        for (i = 0; i < size; i++) begin
            if (!dst_mem.exists(rptr + i)) begin
                $display("receive path never wrote address %0h", rptr + i);
                stop_with_failure();
            end
            check_equal("received word", 64'(dst_mem[rptr + i]), 64'(pkt_words[i]));
        end
        write_reg(ni_pkg::STATUS, 32'hc);   // clear both done flags
        check_equal("irq_o", 64'(irq_o), 64'(0));
        read_reg(ni_pkg::STATUS, rd);
        check_equal("STATUS", 64'(rd), 64'(0));
    endtask

    initial begin
        int          fd;
        int          code;
        int          npkt;
        int          i;
        string       line;
        logic [31:0] w;
        void'($urandom(32));
        reset     = 1'b1;
        ep_addr_i = EP_ADDR;
        s_stb_i   = 1'b0;
        s_we_i    = 1'b0;
        s_addr_i  = 4'h0;
        s_dat_i   = 32'h0;
        npkt      = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_equal("outputs after reset",
                    64'({s_ack_o, m_rd_stb_o, m_wr_stb_o, flit_wr_o, credit_o, irq_o}), 64'(0));
        fd = $fopen("bench/golden_packets.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/golden_packets.txt");
            stop_with_failure();
        end
        for (i = 0; i < 2; i++) begin   // two column description lines
            code = $fgets(line, fd);
            if (code == 0) begin
                $display("golden file ended before its column description lines");
                stop_with_failure();
            end
        end
        while ($fscanf(fd, "%h %h %h %h %h", dest, sptr, rptr, size, hdr) == 5) begin
            pkt_words.delete();
            for (i = 0; i < size; i++) begin
                if ($fscanf(fd, "%h", w) != 1) begin
                    $display("golden file ended inside packet %0d", npkt);
                    stop_with_failure();
                end
                pkt_words.push_back(w);
            end
            run_packet();
            npkt++;
        end
        $fclose(fd);
        if (npkt == 0) begin
            $display("golden file held no packets");
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* logic/ni_depacketizer.sv */
`timescale 1ns/100ps
// receive DMA, takes the header apart and writes the packet words to memory
module ni_depacketizer #(
    parameter int ADDR_W = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      recv_start_i,
    input  logic [ADDR_W-1:0]         recv_ptr_i,
    input  logic [ni_pkg::FLIT_W-1:0] fifo_dout_i,
    input  logic                      fifo_valid_i,
    output logic                      fifo_rd_o,
    output logic                      recv_busy_o,
    output logic                      recv_done_o,
    output logic [ni_pkg::EP_W-1:0]   recv_src_o,
    output logic [ni_pkg::SIZE_W-1:0] recv_size_o,
    output logic                      m_wr_stb_o,
    output logic [ADDR_W-1:0]         m_wr_addr_o,
    output logic [ni_pkg::DATA_W-1:0] m_wr_dat_o,
    input  logic                      m_wr_ack_i
);
    ni_pkg::recv_state_t state;
    ni_pkg::flit_kind_t  kind;
    logic                take_hdr;
    logic                take_word;

    assign kind        = ni_pkg::flit_kind_t'(fifo_dout_i[ni_pkg::FLIT_W-1 -: 2]);
    assign take_hdr    = state == ni_pkg::RCV_HDR && fifo_valid_i;
    assign m_wr_stb_o  = state == ni_pkg::RCV_WRITE && fifo_valid_i;   // held while head waits
    assign take_word   = m_wr_stb_o && m_wr_ack_i;
    assign fifo_rd_o   = take_hdr || take_word;
    assign m_wr_dat_o  = fifo_dout_i[ni_pkg::DATA_W-1:0];
    assign recv_busy_o = state != ni_pkg::RCV_IDLE;
    assign recv_done_o = state == ni_pkg::RCV_DONE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ni_pkg::RCV_IDLE;
            recv_src_o  <= '0;
            recv_size_o <= '0;
        end else begin
            case (state)
                ni_pkg::RCV_IDLE: begin
                    if (recv_start_i)
                        state <= ni_pkg::RCV_HDR;
                end
                ni_pkg::RCV_HDR: begin
                    if (take_hdr) begin
                        recv_src_o  <= fifo_dout_i[ni_pkg::HDR_SRC_LSB +: ni_pkg::EP_W];
                        recv_size_o <= fifo_dout_i[ni_pkg::HDR_SIZE_LSB +: ni_pkg::SIZE_W];
                        state       <= ni_pkg::RCV_WRITE;
                    end
                end
                ni_pkg::RCV_WRITE: begin
                    if (take_word && kind == ni_pkg::FLIT_TAIL)
                        state <= ni_pkg::RCV_DONE;
                end
                default: state <= ni_pkg::RCV_IDLE;
            endcase
        end
    end

    // word address, recv_ptr plus index
    always_ff @(posedge clk) begin
        if (state == ni_pkg::RCV_IDLE && recv_start_i)
            m_wr_addr_o <= recv_ptr_i;
        else if (take_word)
            m_wr_addr_o <= m_wr_addr_o + 1'b1;
    end

    a_hdr_first: assert property (
        @(posedge clk) disable iff (reset) take_hdr |-> kind == ni_pkg::FLIT_HDR)
        else $error("packet did not start with a header flit");

endmodule

/* logic/ni_flit_fifo.sv */
`timescale 1ns/100ps
// receive flit buffer, first-word-fall-through
// returns one credit per flit read
module ni_flit_fifo #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [ni_pkg::FLIT_W-1:0] flit_i,
    input  logic                      flit_wr_i,
    input  logic                      fifo_rd_i,
    output logic [ni_pkg::FLIT_W-1:0] fifo_dout_o,
    output logic                      fifo_valid_o,
    output logic                      credit_o
);
    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [ni_pkg::FLIT_W-1:0] mem [BUF_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      rd;

    assign rd           = fifo_rd_i & fifo_valid_o;
    assign fifo_valid_o = count != '0;
    assign fifo_dout_o  = mem[rd_ptr];   // head flit visible without a read

    always_ff @(posedge clk) begin
        if (flit_wr_i)
            mem[wr_ptr] <= flit_i;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (flit_wr_i)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at the power of two depth
            if (rd)
                rd_ptr <= rd_ptr + 1'b1;
            count    <= count + CNT_W'(flit_wr_i) - CNT_W'(rd);
            credit_o <= rd;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) flit_wr_i |-> count != CNT_W'(BUF_DEPTH))
        else $error("flit arrived with the buffer full");

endmodule

/* logic/ni_packetizer.sv */
`timescale 1ns/100ps
// send DMA that reads a memory block and emits it as header, body and tail flits
// under downstream credit control
module ni_packetizer #(
    parameter int BUF_DEPTH = 8,
    parameter int ADDR_W    = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [ni_pkg::EP_W-1:0]   ep_addr_i,
    input  logic                      send_start_i,
    input  logic [ni_pkg::EP_W-1:0]   send_dest_i,
    input  logic [ADDR_W-1:0]         send_ptr_i,
    input  logic [ni_pkg::SIZE_W-1:0] send_size_i,
    output logic                      send_busy_o,
    output logic                      send_done_o,
    output logic                      m_rd_stb_o,
    output logic [ADDR_W-1:0]         m_rd_addr_o,
    input  logic [ni_pkg::DATA_W-1:0] m_rd_dat_i,
    input  logic                      m_rd_ack_i,
    output logic [ni_pkg::FLIT_W-1:0] flit_o,
    output logic                      flit_wr_o,
    input  logic                      credit_i
);
    localparam int CRD_W = $clog2(BUF_DEPTH + 1);

    ni_pkg::send_state_t       state;
    logic [CRD_W-1:0]          credit_cnt;
    logic [ni_pkg::EP_W-1:0]   dest_q;
    logic [ni_pkg::SIZE_W-1:0] size_q;
    logic [ni_pkg::SIZE_W-1:0] words_left;
    logic [ni_pkg::DATA_W-1:0] word_q;
    logic [ni_pkg::DATA_W-1:0] hdr_payload;
    logic                      has_credit;
    logic                      emit_word;

    assign has_credit  = credit_cnt != '0;
    assign emit_word   = state == ni_pkg::SND_WAIT_CREDIT && has_credit;
    assign flit_wr_o   = (state == ni_pkg::SND_HDR && has_credit) || emit_word;
    assign m_rd_stb_o  = state == ni_pkg::SND_READ;
    assign send_busy_o = state != ni_pkg::SND_IDLE;
    assign send_done_o = state == ni_pkg::SND_DONE;

    always_comb begin
        hdr_payload = '0;
        hdr_payload[ni_pkg::HDR_DEST_LSB +: ni_pkg::EP_W]   = dest_q;
        hdr_payload[ni_pkg::HDR_SRC_LSB +: ni_pkg::EP_W]    = ep_addr_i;
        hdr_payload[ni_pkg::HDR_SIZE_LSB +: ni_pkg::SIZE_W] = size_q;
        if (state == ni_pkg::SND_HDR)
            flit_o = {ni_pkg::FLIT_HDR, hdr_payload};
        else if (words_left == 1)
            flit_o = {ni_pkg::FLIT_TAIL, word_q};   // last word closes the packet
        else
            flit_o = {ni_pkg::FLIT_BODY, word_q};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ni_pkg::SND_IDLE;
            words_left <= '0;
        end else begin
            case (state)
                ni_pkg::SND_IDLE: begin
                    if (send_start_i) begin
                        words_left <= send_size_i;
                        state      <= ni_pkg::SND_HDR;
                    end
                end
                ni_pkg::SND_HDR: begin
                    if (has_credit)
                        state <= (words_left == '0) ? ni_pkg::SND_DONE : ni_pkg::SND_READ;
                end
                ni_pkg::SND_READ: begin
                    if (m_rd_ack_i)
                        state <= ni_pkg::SND_WAIT_CREDIT;
                end
                ni_pkg::SND_WAIT_CREDIT: begin   // word held until a slot is free
                    if (has_credit) begin
                        words_left <= words_left - 1'b1;
                        state      <= (words_left == 1) ? ni_pkg::SND_DONE : ni_pkg::SND_READ;
                    end
                end
                default: state <= ni_pkg::SND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ni_pkg::SND_IDLE && send_start_i) begin
            dest_q      <= send_dest_i;
            size_q      <= send_size_i;
            m_rd_addr_o <= send_ptr_i;
        end else if (emit_word) begin
            m_rd_addr_o <= m_rd_addr_o + 1'b1;   // next word address
        end
        if (m_rd_stb_o && m_rd_ack_i)
            word_q <= m_rd_dat_i;
    end

    // a flit and a returned credit in one cycle cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            credit_cnt <= CRD_W'(BUF_DEPTH);
        else if (flit_wr_o && !credit_i)
            credit_cnt <= credit_cnt - 1'b1;
        else if (!flit_wr_o && credit_i)
            credit_cnt <= credit_cnt + 1'b1;
    end

    // every returned credit belongs to a flit still outstanding
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        credit_i && !flit_wr_o |-> credit_cnt < CRD_W'(BUF_DEPTH))
        else $error("credit returned with every downstream slot already free");

endmodule

/* logic/ni_pkg.sv */
// network interface shared definitions
// widths, flit flags, register map and FSM states
package ni_pkg;

    parameter int DATA_W = 32;
    parameter int FLIT_W = DATA_W + 2;   // payload plus flag bits
    parameter int EP_W   = 8;
    parameter int SIZE_W = 10;           // up to 1023 words per packet

    // header payload field positions
    parameter int HDR_DEST_LSB = 0;
    parameter int HDR_SRC_LSB  = 8;
    parameter int HDR_SIZE_LSB = 16;

    // top two flit bits
    typedef enum logic [1:0] {
        FLIT_BODY = 2'b00,
        FLIT_TAIL = 2'b01,
        FLIT_HDR  = 2'b10
    } flit_kind_t;

    typedef enum logic [3:0] {
        STATUS     = 4'd0,
        SEND_DEST  = 4'd1,
        SEND_PTR   = 4'd2,
        SEND_SIZE  = 4'd3,
        SEND_START = 4'd4,
        RECV_PTR   = 4'd5,
        RECV_SRC   = 4'd6,
        RECV_SIZE  = 4'd7,
        RECV_START = 4'd8,
        IRQ_EN     = 4'd9
    } reg_addr_t;

    typedef enum logic [2:0] {
        SND_IDLE,
        SND_HDR,
        SND_READ,
        SND_WAIT_CREDIT,
        SND_DONE
    } send_state_t;

    typedef enum logic [1:0] {
        RCV_IDLE,
        RCV_HDR,
        RCV_WRITE,
        RCV_DONE
    } recv_state_t;

endpackage

/* logic/ni_regs.sv */
`timescale 1ns/100ps
// register slave with single-cycle ack
// holds transfer setup, done flags and interrupt enables
module ni_regs #(
    parameter int ADDR_W = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      s_stb_i,
    input  logic                      s_we_i,
    input  logic [3:0]                s_addr_i,
    input  logic [ni_pkg::DATA_W-1:0] s_dat_i,
    output logic [ni_pkg::DATA_W-1:0] s_dat_o,
    output logic                      s_ack_o,
    output logic                      irq_o,
    input  logic                      send_busy_i,
    input  logic                      send_done_i,
    input  logic                      recv_busy_i,
    input  logic                      recv_done_i,
    input  logic [ni_pkg::EP_W-1:0]   recv_src_i,
    input  logic [ni_pkg::SIZE_W-1:0] recv_size_i,
    input  logic                      fifo_valid_i,
    output logic                      send_start_o,
    output logic [ni_pkg::EP_W-1:0]   send_dest_o,
    output logic [ADDR_W-1:0]         send_ptr_o,
    output logic [ni_pkg::SIZE_W-1:0] send_size_o,
    output logic                      recv_start_o,
    output logic [ADDR_W-1:0]         recv_ptr_o
);
    localparam int DW = ni_pkg::DATA_W;

    ni_pkg::reg_addr_t addr;
    logic              wr;
    logic              clr_status;
    logic              send_done_q;
    logic              recv_done_q;
    logic [1:0]        irq_en;   // bit 0 send, bit 1 receive

    assign addr       = ni_pkg::reg_addr_t'(s_addr_i);
    assign wr         = s_stb_i & s_we_i & ~s_ack_o;   // lands on the ack edge
    assign clr_status = wr && addr == ni_pkg::STATUS;
    assign irq_o      = (send_done_q & irq_en[0]) | (recv_done_q & irq_en[1]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o      <= 1'b0;
            send_start_o <= 1'b0;
            recv_start_o <= 1'b0;
            send_done_q  <= 1'b0;
            recv_done_q  <= 1'b0;
            irq_en       <= 2'b00;
        end else begin
            s_ack_o      <= s_stb_i & ~s_ack_o;
            send_start_o <= wr && addr == ni_pkg::SEND_START && !send_busy_i;
            recv_start_o <= wr && addr == ni_pkg::RECV_START && !recv_busy_i;
            if (wr && addr == ni_pkg::IRQ_EN)
                irq_en <= s_dat_i[1:0];
            // a done pulse wins over a clear in the same cycle
            if (send_done_i)
                send_done_q <= 1'b1;
            else if (clr_status && s_dat_i[2])
                send_done_q <= 1'b0;
            if (recv_done_i)
                recv_done_q <= 1'b1;
            else if (clr_status && s_dat_i[3])
                recv_done_q <= 1'b0;
        end
    end

    // transfer setup
    always_ff @(posedge clk) begin
        if (wr) begin
            case (addr)
                ni_pkg::SEND_DEST: send_dest_o <= s_dat_i[ni_pkg::EP_W-1:0];
                ni_pkg::SEND_PTR:  send_ptr_o  <= ADDR_W'(s_dat_i);
                ni_pkg::SEND_SIZE: send_size_o <= s_dat_i[ni_pkg::SIZE_W-1:0];
                ni_pkg::RECV_PTR:  recv_ptr_o  <= ADDR_W'(s_dat_i);
                default: ;
            endcase
        end
    end

    always_comb begin
        s_dat_o = '0;
        case (addr)
            ni_pkg::STATUS:
                s_dat_o = DW'({fifo_valid_i, recv_done_q, send_done_q, recv_busy_i, send_busy_i});
            ni_pkg::SEND_DEST: s_dat_o = DW'(send_dest_o);
            ni_pkg::SEND_PTR:  s_dat_o = DW'(send_ptr_o);
            ni_pkg::SEND_SIZE: s_dat_o = DW'(send_size_o);
            ni_pkg::RECV_PTR:  s_dat_o = DW'(recv_ptr_o);
            ni_pkg::RECV_SRC:  s_dat_o = DW'(recv_src_i);
            ni_pkg::RECV_SIZE: s_dat_o = DW'(recv_size_i);
            ni_pkg::IRQ_EN:    s_dat_o = DW'(irq_en);
            default: ;
        endcase
    end

    // master lets the strobe go once acked, so every access gets one ack
    a_stb_released: assert property (@(posedge clk) disable iff (reset) s_ack_o |=> !s_stb_i)
        else $error("strobe still high after ack, the access would repeat");

endmodule

/* logic/ni_top.sv */
`timescale 1ns/100ps
// DMA network interface top, register slave, send and receive paths
module ni_top #(
    parameter int BUF_DEPTH = 8,
    parameter int ADDR_W    = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [ni_pkg::EP_W-1:0]   ep_addr_i,
    input  logic                      s_stb_i,
    input  logic                      s_we_i,
    input  logic [3:0]                s_addr_i,
    input  logic [ni_pkg::DATA_W-1:0] s_dat_i,
    output logic [ni_pkg::DATA_W-1:0] s_dat_o,
    output logic                      s_ack_o,
    output logic                      m_rd_stb_o,
    output logic [ADDR_W-1:0]         m_rd_addr_o,
    input  logic [ni_pkg::DATA_W-1:0] m_rd_dat_i,
    input  logic                      m_rd_ack_i,
    output logic                      m_wr_stb_o,
    output logic [ADDR_W-1:0]         m_wr_addr_o,
    output logic [ni_pkg::DATA_W-1:0] m_wr_dat_o,
    input  logic                      m_wr_ack_i,
    output logic [ni_pkg::FLIT_W-1:0] flit_o,
    output logic                      flit_wr_o,
    input  logic                      credit_i,
    input  logic [ni_pkg::FLIT_W-1:0] flit_i,
    input  logic                      flit_wr_i,
    output logic                      credit_o,
    output logic                      irq_o
);
    logic                      send_start;
    logic [ni_pkg::EP_W-1:0]   send_dest;
    logic [ADDR_W-1:0]         send_ptr;
    logic [ni_pkg::SIZE_W-1:0] send_size;
    logic                      send_busy;
    logic                      send_done;
    logic                      recv_start;
    logic [ADDR_W-1:0]         recv_ptr;
    logic                      recv_busy;
    logic                      recv_done;
    logic [ni_pkg::EP_W-1:0]   recv_src;
    logic [ni_pkg::SIZE_W-1:0] recv_size;
    logic [ni_pkg::FLIT_W-1:0] fifo_dout;
    logic                      fifo_valid;
    logic                      fifo_rd;

    ni_regs #(.ADDR_W(ADDR_W)) ni_regs_i (
        .clk(clk), .reset(reset),
        .s_stb_i(s_stb_i), .s_we_i(s_we_i), .s_addr_i(s_addr_i), .s_dat_i(s_dat_i),
        .s_dat_o(s_dat_o), .s_ack_o(s_ack_o), .irq_o(irq_o),
        .send_busy_i(send_busy), .send_done_i(send_done),
        .recv_busy_i(recv_busy), .recv_done_i(recv_done),
        .recv_src_i(recv_src), .recv_size_i(recv_size), .fifo_valid_i(fifo_valid),
        .send_start_o(send_start), .send_dest_o(send_dest),
        .send_ptr_o(send_ptr), .send_size_o(send_size),
        .recv_start_o(recv_start), .recv_ptr_o(recv_ptr)
    );

    ni_packetizer #(.BUF_DEPTH(BUF_DEPTH), .ADDR_W(ADDR_W)) ni_packetizer_i (
        .clk(clk), .reset(reset), .ep_addr_i(ep_addr_i),
        .send_start_i(send_start), .send_dest_i(send_dest),
        .send_ptr_i(send_ptr), .send_size_i(send_size),
        .send_busy_o(send_busy), .send_done_o(send_done),
        .m_rd_stb_o(m_rd_stb_o), .m_rd_addr_o(m_rd_addr_o),
        .m_rd_dat_i(m_rd_dat_i), .m_rd_ack_i(m_rd_ack_i),
        .flit_o(flit_o), .flit_wr_o(flit_wr_o), .credit_i(credit_i)
    );

    ni_flit_fifo #(.BUF_DEPTH(BUF_DEPTH)) ni_flit_fifo_i (
        .clk(clk), .reset(reset),
        .flit_i(flit_i), .flit_wr_i(flit_wr_i), .fifo_rd_i(fifo_rd),
        .fifo_dout_o(fifo_dout), .fifo_valid_o(fifo_valid), .credit_o(credit_o)
    );

    ni_depacketizer #(.ADDR_W(ADDR_W)) ni_depacketizer_i (
        .clk(clk), .reset(reset),
        .recv_start_i(recv_start), .recv_ptr_i(recv_ptr),
        .fifo_dout_i(fifo_dout), .fifo_valid_i(fifo_valid), .fifo_rd_o(fifo_rd),
        .recv_busy_o(recv_busy), .recv_done_o(recv_done),
        .recv_src_o(recv_src), .recv_size_o(recv_size),
        .m_wr_stb_o(m_wr_stb_o), .m_wr_addr_o(m_wr_addr_o),
        .m_wr_dat_o(m_wr_dat_o), .m_wr_ack_i(m_wr_ack_i)
    );

endmodule
